// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_uart_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "FAIL: run ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: project.f
uart_pkg.sv
uart_fifo.sv
uart_baud_gen.sv
uart_regs.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_props.sv
tb_uart_top.sv

// File: tb_uart_top.sv
// uart peripheral testbench
`timescale 1ns/10ps
`default_nettype none

module tb_uart_top import uart_pkg::*; ();

    localparam int DEPTH    = DEFAULT_FIFO_DEPTH;
    localparam int BIT_CLKS = 32;   // divisor 1 gives 16 ticks of 2 clocks
    localparam int POLLS    = 4000;

    logic       clk_i = 1'b0;
    logic       rst_i;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic       uart_rx;
    logic       uart_tx;
    logic       loop_sel;           // 1 feeds tx back into rx
    logic       drv_line;
    int         errors;
    integer     seed;
    logic [7:0] model_q [$];

    assign uart_rx = loop_sel ? uart_tx : drv_line;

    uart_top #(.FIFO_DEPTH(DEPTH)) u_uart_top (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wb_req_i  (wb_req),
        .wb_rsp_o  (wb_rsp),
        .uart_rx_i (uart_rx),
        .uart_tx_o (uart_tx)
    );

    always #4 clk_i = ~clk_i;

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, output logic [31:0] rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        @(negedge clk_i);
        wb_req = '{adr: adr, dat: dat, we: we, stb: 1'b1, cyc: 1'b1, sel: sel};
        do begin
            @(negedge clk_i);
            waited++;
        end while (!wb_rsp.ack && waited < 20);
        if (wb_rsp.ack) begin
            rdata = wb_rsp.dat;
        end else begin
            $display("ERROR at %0t: no ack for bus cycle to offset %h", $time, adr);
            errors++;
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic bus_write(input logic [3:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, dat, sel, unused);
    endtask

    // polls the status word until one bit reaches the wanted level
    task automatic wait_status(input int idx, input logic level, input string what);
        logic [31:0] stat;
        int polls;
        polls = 0;
        bus_cycle(1'b0, ADR_STAT, '0, 4'hF, stat);
        while (stat[idx] !== level && polls < POLLS) begin
            bus_cycle(1'b0, ADR_STAT, '0, 4'hF, stat);
            polls++;
        end
        if (stat[idx] !== level) begin
            $display("ERROR at %0t: timed out waiting for %s", $time, what);
            errors++;
        end
    endtask

    task automatic drive_frame(input logic [7:0] data, input logic stop);
        @(negedge clk_i);
        drv_line = 1'b0;
        repeat (BIT_CLKS) @(negedge clk_i);
        for (int i = 0; i < 8; i++) begin
            drv_line = data[i];
            repeat (BIT_CLKS) @(negedge clk_i);
        end
        drv_line = stop;
        repeat (BIT_CLKS) @(negedge clk_i);
        drv_line = 1'b1;
        repeat (BIT_CLKS) @(negedge clk_i);
    endtask

    task automatic check_tx_frame(input logic [7:0] data);
        int waited;
        waited = 0;
        while (uart_tx && waited < 2000) begin
            @(negedge clk_i);
            waited++;
        end
        if (uart_tx) begin
            $display("ERROR at %0t: no start bit on uart_tx_o", $time);
            errors++;
        end else begin
            repeat (BIT_CLKS / 2) @(negedge clk_i); // mid start bit
            expect_equal("uart_tx_o start", 32'(uart_tx), 32'd0);
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge clk_i);
                expect_equal("uart_tx_o data", 32'(uart_tx), 32'(data[i]));
            end
            repeat (BIT_CLKS) @(negedge clk_i);
            expect_equal("uart_tx_o stop", 32'(uart_tx), 32'd1);
        end
    endtask

    task automatic receive_and_check(input int count);
        logic [31:0] rd;
        logic [7:0]  exp;
        for (int i = 0; i < count; i++) begin
            wait_status(2, 1'b0, "receive data");
            bus_cycle(1'b0, ADR_RXD, '0, 4'hF, rd);
            exp = model_q.pop_front();
            expect_equal("rx data", rd, {24'b0, exp}); // frame_err clear
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d check, %0d assertion", errors, u_uart_top.u_props.fail_count);
    endtask

    initial begin
        logic [31:0] rd;
        logic [7:0]  b;
        logic        low_seen;
        rst_i    = 1'b1;
        wb_req   = '0;
        loop_sel = 1'b0;
        drv_line = 1'b1;
        errors   = 0;
        seed     = 32'h7f86bd74;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // byte lanes of the control word
        bus_write(ADR_CTRL, 32'h0005_0003, 4'hF);
        bus_cycle(1'b0, ADR_CTRL, '0, 4'hF, rd);
        expect_equal("ctrl", rd, 32'h0005_0003);
        bus_write(ADR_CTRL, 32'h0009_0002, 4'h1);
        bus_cycle(1'b0, ADR_CTRL, '0, 4'hF, rd);
        expect_equal("ctrl", rd, 32'h0005_0002);

        bus_write(ADR_CTRL, 32'h0001_0001, 4'hF);
        b = 8'($random(seed));
        bus_write(ADR_TXD, {24'b0, b}, 4'h1);
        check_tx_frame(b);

        drive_frame(8'hA5, 1'b1); // rx_en clear, must be ignored
        bus_cycle(1'b0, ADR_STAT, '0, 4'hF, rd);
        expect_equal("rx_empty", 32'(rd[2]), 32'd1);

        loop_sel = 1'b1;
        bus_write(ADR_CTRL, 32'h0001_0003, 4'hF);
        for (int i = 0; i < DEPTH; i++) begin
            b = 8'($random(seed));
            model_q.push_back(b);
            bus_write(ADR_TXD, {24'b0, b}, 4'h1);
        end
        receive_and_check(DEPTH);
        bus_cycle(1'b0, ADR_RXD, '0, 4'hF, rd);
        expect_equal("rx data empty", rd, 32'd0);

        // stall the serializer and overflow its fifo
        bus_write(ADR_CTRL, 32'h0001_0002, 4'hF);
        for (int i = 0; i <= DEPTH; i++) begin
            b = 8'($random(seed));
            if (i < DEPTH) begin
                model_q.push_back(b);
            end
            bus_write(ADR_TXD, {24'b0, b}, 4'h1);
        end
        bus_cycle(1'b0, ADR_STAT, '0, 4'hF, rd);
        expect_equal("tx_full", 32'(rd[0]), 32'd1);
        low_seen = 1'b0;
        repeat (4 * BIT_CLKS) begin
            @(negedge clk_i);
            low_seen = low_seen | ~uart_tx;
        end
        expect_equal("uart_tx_o while stalled", 32'(low_seen), 32'd0);
        bus_write(ADR_CTRL, 32'h0001_0003, 4'hF);
        wait_status(3, 1'b1, "receive fifo full");
        receive_and_check(DEPTH);
        wait_status(1, 1'b1, "transmit fifo empty");
        repeat (10 * BIT_CLKS) @(negedge clk_i);
        bus_cycle(1'b0, ADR_STAT, '0, 4'hF, rd);
        expect_equal("rx_empty after overflow", 32'(rd[2]), 32'd1);

        // low stop bit
        loop_sel = 1'b0;
        b = 8'($random(seed));
        drive_frame(b, 1'b0);
        wait_status(2, 1'b0, "frame with stop error");
        bus_cycle(1'b0, ADR_RXD, '0, 4'hF, rd);
        expect_equal("rx data frame_err", rd, {23'b0, 1'b1, b});

        print_counts();
        if (errors == 0 && u_uart_top.u_props.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #1000000;
        $display("ERROR at %0t: simulation watchdog expired", $time);
        print_counts();
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_baud_gen.sv
// oversampling tick generator
`timescale 1ns/10ps
`default_nettype none

module uart_baud_gen import uart_pkg::*; (
    input  wire             clk_i,
    input  wire             rst_i,
    input  wire [DIV_W-1:0] baud_div_i,
    input  wire             div_load_i,
    output logic            tick_o
);

    logic [DIV_W-1:0] count;

    // tick period is divisor plus one clocks
    always_ff @(posedge clk_i) begin
        if (rst_i || div_load_i) begin
            count  <= '0; // restart on a new divisor
            tick_o <= 1'b0;
        end else if (count == baud_div_i) begin
            count  <= '0;
            tick_o <= 1'b1;
        end else begin
            count  <= count + 1'b1;
            tick_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: uart_fifo.sv
// synchronous fifo
`timescale 1ns/10ps
`default_nettype none

module uart_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  wire           clk_i,
    input  wire           rst_i,
    input  wire           push_i,
    input  wire payload_t data_i,
    input  wire           pop_i,
    output payload_t      data_o,
    output logic          full_o,
    output logic          empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign full_o  = (count == CNT_W'(DEPTH));
    assign empty_o = (count == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;
    assign data_o  = mem[rd_ptr]; // head falls through

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: uart_pkg.sv
// uart shared definitions
`default_nettype none

package uart_pkg;

    // register offsets
    localparam logic [3:0] ADR_CTRL = 4'h0;
    localparam logic [3:0] ADR_STAT = 4'h4;
    localparam logic [3:0] ADR_RXD  = 4'h8;
    localparam logic [3:0] ADR_TXD  = 4'hC;

    localparam int OVERSAMPLE         = 16; // ticks per bit
    localparam int DEFAULT_FIFO_DEPTH = 4;
    localparam int DIV_W              = 16; // baud divisor width

    // bus master to slave
    typedef struct packed {
        logic [3:0]  adr;
        logic [31:0] dat;
        logic        we;
        logic        stb;
        logic        cyc;
        logic [3:0]  sel;
    } wb_req_t;

    // slave back to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // one received frame, frame_err lands in bit 8
    typedef struct packed {
        logic       frame_err;
        logic [7:0] data;
    } rx_frame_t;

endpackage

`default_nettype wire

// File: uart_props.sv
// uart bus and serial assertions
`timescale 1ns/10ps
`default_nettype none

module uart_props import uart_pkg::*; (
    input wire          clk_i,
    input wire          rst_i,
    input wire wb_req_t wb_req_i,
    input wire wb_rsp_t wb_rsp_i,
    input wire          tx_line_i,
    input wire          tx_busy_i
);

    int ack_hold_fails   = 0;
    int ack_orphan_fails = 0;
    int idle_line_fails  = 0;
    int fail_count;

    assign fail_count = ack_hold_fails + ack_orphan_fails + idle_line_fails;

    a_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_rsp_i.ack |=> !wb_rsp_i.ack) else begin
        $error("ack stayed high for two cycles");
        ack_hold_fails++;
    end

    // ack only one cycle after an accepted request
    a_ack_accepted: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_rsp_i.ack |-> $past(wb_req_i.cyc && wb_req_i.stb && !wb_rsp_i.ack)) else begin
        $error("ack without an accepted request");
        ack_orphan_fails++;
    end

    a_idle_high: assert property (@(posedge clk_i) disable iff (rst_i)
        !tx_busy_i |-> tx_line_i) else begin
        $error("serial output low while the serializer is idle");
        idle_line_fails++;
    end

endmodule

bind uart_top uart_props u_props (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wb_req_i  (wb_req_i),
    .wb_rsp_i  (wb_rsp_o),
    .tx_line_i (uart_tx_o),
    .tx_busy_i (u_tx.busy)
);

`default_nettype wire

// File: uart_regs.sv
// wishbone register bank
`timescale 1ns/10ps
`default_nettype none

module uart_regs import uart_pkg::*; (
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire wb_req_t     wb_req_i,
    output wb_rsp_t          wb_rsp_o,
    input  wire              tx_full_i,
    input  wire              tx_empty_i,
    input  wire              rx_full_i,
    input  wire              rx_empty_i,
    input  wire rx_frame_t   rx_head_i,
    output logic             tx_push_o,
    output logic [7:0]       tx_byte_o,
    output logic             rx_pop_o,
    output logic             tx_en_o,
    output logic             rx_en_o,
    output logic [DIV_W-1:0] baud_div_o,
    output logic             div_load_o
);

    logic        ack_q;
    logic [31:0] rdata_q;
    logic [31:0] rd_data;
    logic        accept;
    logic        ctrl_wr;

    // one request per ack, a held stb gets every other cycle
    assign accept  = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign ctrl_wr = accept & wb_req_i.we & (wb_req_i.adr == ADR_CTRL);

    // strobes fire in the accept cycle
    assign tx_push_o  = accept & wb_req_i.we & (wb_req_i.adr == ADR_TXD);
    assign tx_byte_o  = wb_req_i.dat[7:0];
    assign rx_pop_o   = accept & ~wb_req_i.we & (wb_req_i.adr == ADR_RXD) & ~rx_empty_i;
    assign div_load_o = ctrl_wr & (&wb_req_i.sel[3:2]); // divisor needs both upper lanes

    always_comb begin
        rd_data = '0;
        case (wb_req_i.adr)
            ADR_CTRL: begin
                rd_data = {baud_div_o, 14'b0, rx_en_o, tx_en_o};
            end
            ADR_STAT: begin
                rd_data = {28'b0, rx_full_i, rx_empty_i, tx_empty_i, tx_full_i};
            end
            ADR_RXD: begin
                if (!rx_empty_i) begin
                    rd_data = {23'b0, rx_head_i}; // head before the pop
                end
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q      <= 1'b0;
            tx_en_o    <= 1'b0;
            rx_en_o    <= 1'b0;
            baud_div_o <= '0;
        end else begin
            ack_q <= accept;
            if (ctrl_wr && wb_req_i.sel[0]) begin
                tx_en_o <= wb_req_i.dat[0];
                rx_en_o <= wb_req_i.dat[1];
            end
            if (div_load_o) begin
                baud_div_o <= wb_req_i.dat[31:16];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rdata_q <= rd_data;
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rdata_q};

endmodule

`default_nettype wire

// File: uart_rx.sv
// 8n1 deserializer
`timescale 1ns/10ps
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  wire       clk_i,
    input  wire       rst_i,
    input  wire       tick_i,
    input  wire       rx_en_i,
    input  wire       rx_i,
    output logic      push_o,
    output rx_frame_t frame_o
);

    localparam int TW = $clog2(OVERSAMPLE);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e     state;
    logic          rx_meta;
    logic          rx_sync;
    logic [TW-1:0] tick_cnt;
    logic [2:0]    bit_cnt;
    logic [7:0]    shreg;
    logic          bit_end;

    assign bit_end = tick_i && (tick_cnt == TW'(OVERSAMPLE - 1));

    // push on the stop sample tick itself
    assign push_o  = bit_end && (state == RX_STOP);
    assign frame_o = '{frame_err: ~rx_sync, data: shreg};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (tick_i) begin
            case (state)
                RX_IDLE: begin
                    if (rx_en_i && !rx_sync) begin
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == TW'(OVERSAMPLE / 2 - 1)) begin // mid start bit
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? RX_IDLE : RX_DATA; // high again is a glitch
                    end
                end
                RX_DATA: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (bit_end) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk_i) begin
        if (bit_end && state == RX_DATA) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
    end

endmodule

`default_nettype wire

// File: uart_top.sv
// uart peripheral top level
`timescale 1ns/10ps
`default_nettype none

module uart_top import uart_pkg::*; #(
    parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
    input  wire          clk_i,
    input  wire          rst_i,
    input  wire wb_req_t wb_req_i,
    output wb_rsp_t      wb_rsp_o,
    input  wire          uart_rx_i,
    output logic         uart_tx_o
);

    logic             tx_push;
    logic [7:0]       tx_byte;
    logic             tx_pop;
    logic [7:0]       tx_head;
    logic             tx_full;
    logic             tx_empty;
    logic             rx_push;
    rx_frame_t        rx_frame;
    logic             rx_pop;
    rx_frame_t        rx_head;
    logic             rx_full;
    logic             rx_empty;
    logic             tx_en;
    logic             rx_en;
    logic [DIV_W-1:0] baud_div;
    logic             div_load;
    logic             tick;

    uart_regs u_regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wb_req_i   (wb_req_i),
        .wb_rsp_o   (wb_rsp_o),
        .tx_full_i  (tx_full),
        .tx_empty_i (tx_empty),
        .rx_full_i  (rx_full),
        .rx_empty_i (rx_empty),
        .rx_head_i  (rx_head),
        .tx_push_o  (tx_push),
        .tx_byte_o  (tx_byte),
        .rx_pop_o   (rx_pop),
        .tx_en_o    (tx_en),
        .rx_en_o    (rx_en),
        .baud_div_o (baud_div),
        .div_load_o (div_load)
    );

    uart_baud_gen u_baud_gen (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .baud_div_i (baud_div),
        .div_load_i (div_load),
        .tick_o     (tick)
    );

    uart_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(logic [7:0])) u_tx_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .push_i  (tx_push),
        .data_i  (tx_byte),
        .pop_i   (tx_pop),
        .data_o  (tx_head),
        .full_o  (tx_full),
        .empty_o (tx_empty)
    );

    uart_tx u_tx (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .tick_i  (tick),
        .tx_en_i (tx_en),
        .empty_i (tx_empty),
        .data_i  (tx_head),
        .pop_o   (tx_pop),
        .tx_o    (uart_tx_o)
    );

    uart_rx u_rx (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .tick_i  (tick),
        .rx_en_i (rx_en),
        .rx_i    (uart_rx_i),
        .push_o  (rx_push),
        .frame_o (rx_frame)
    );

    uart_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(rx_frame_t)) u_rx_fifo (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .push_i  (rx_push),
        .data_i  (rx_frame),
        .pop_i   (rx_pop),
        .data_o  (rx_head),
        .full_o  (rx_full),
        .empty_o (rx_empty)
    );

endmodule

`default_nettype wire

// File: uart_tx.sv
// 8n1 serializer
`timescale 1ns/10ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  wire       clk_i,
    input  wire       rst_i,
    input  wire       tick_i,
    input  wire       tx_en_i,
    input  wire       empty_i,
    input  wire [7:0] data_i,
    output logic      pop_o,
    output logic      tx_o
);

    localparam int TW = $clog2(OVERSAMPLE);

    logic          busy;
    logic [TW-1:0] tick_cnt;
    logic [3:0]    bit_cnt;  // 0 start, 1..8 data, 9 stop
    logic [8:0]    shreg;    // data then stop

    // a frame starts only from idle, tx_en does not cut one short
    assign pop_o = tick_i & ~busy & tx_en_i & ~empty_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy     <= 1'b0;
            tx_o     <= 1'b1;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (pop_o) begin
            busy     <= 1'b1;
            tx_o     <= 1'b0; // start bit
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (busy && tick_i) begin
            tick_cnt <= tick_cnt + 1'b1;
            if (tick_cnt == TW'(OVERSAMPLE - 1)) begin
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0; // line already high from stop
                end else begin
                    tx_o    <= shreg[0];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            shreg <= {1'b1, data_i};
        end else if (busy && tick_i && tick_cnt == TW'(OVERSAMPLE - 1)) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule

`default_nettype wire
